//--- Makefile
# Verilator build and run for the aligner testbench
VERILATOR ?= verilator
TOP       ?= tb_aligner
FLIST     ?= aligner.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail if the log reports failure"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "TESTS FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- aligner.f
verilog/aligner_pkg.sv
verilog/md_rx_ctrl.sv
verilog/sync_fifo.sv
verilog/md_tx_aligner.sv
verilog/apb_regs.sv
verilog/aligner_top.sv
tests/aligner_assertions.sv
tests/tb_aligner.sv

//--- tests/aligner_assertions.sv
// MD handshake protocol assertions, bound to the receive controller and the aligner
module aligner_assertions #(
    parameter int unsigned W = 64
) (
    input logic         pclk,
    input logic         rst_n,
    input logic         valid,
    input logic         ready,
    input logic [W-1:0] fields,
    input logic         err,
    input logic         reset_low
);

    // Valid and fields held until the handshake
    assert property (@(posedge pclk) disable iff (!rst_n)
        valid && !ready |=> valid && $stable(fields))
        else $error("MD valid or fields changed before ready");

    // Err only together with ready
    assert property (@(posedge pclk) disable iff (!rst_n) err |-> ready)
        else $error("MD err without ready");

    // Low in the cycle after reset
    assert property (@(posedge pclk) !rst_n |=> !reset_low)
        else $error("MD handshake signal high after reset");

endmodule

bind md_rx_ctrl aligner_assertions rx_checks (
    .pclk(pclk), .rst_n(rst_n), .valid(md_rx_valid), .ready(md_rx_ready),
    .fields(64'({md_rx_data, md_rx_offset, md_rx_size})), .err(md_rx_err),
    .reset_low(md_rx_ready)
);

bind md_tx_aligner aligner_assertions tx_checks (
    .pclk(pclk), .rst_n(rst_n), .valid(md_tx_valid), .ready(md_tx_ready),
    .fields(64'({md_tx_data, md_tx_offset, md_tx_size})), .err(1'b0),
    .reset_low(md_tx_valid)
);

//--- tests/tb_aligner.sv
// Aligner testbench: clock, reset, LFSR stimulus, byte queue model, checks, watchdog
module tb_aligner import aligner_pkg::*;;

    localparam int DW    = 32;
    localparam int BYTES = DW / 8;
    localparam int DEPTH = 8;
    localparam int AW    = 16;
    // Watchdog bound
    localparam int TOTAL_XFERS     = 800;
    localparam int CYCLES_PER_XFER = 40;

    logic          pclk;
    logic          rst_n;
    logic [AW-1:0] paddr;
    logic          pwrite;
    logic          psel;
    logic          penable;
    logic [31:0]   pwdata;
    logic          pready;
    logic [31:0]   prdata;
    logic          pslverr;
    logic          md_rx_valid;
    logic [DW-1:0] md_rx_data;
    logic [1:0]    md_rx_offset;
    logic [2:0]    md_rx_size;
    logic          md_rx_ready;
    logic          md_rx_err;
    logic          md_tx_valid;
    logic [DW-1:0] md_tx_data;
    logic [1:0]    md_tx_offset;
    logic [2:0]    md_tx_size;
    logic          md_tx_ready;

    logic [7:0]  model_q [$];
    logic [31:0] stim_lfsr = 32'd58;
    logic [31:0] rdy_lfsr  = 32'd58;
    int          errors    = 0;
    int          checks    = 0;
    int          exp_size  = BYTES;
    int          exp_offset = 0;
    bit          tx_rand   = 1'b1;

    aligner_top #(.ALGN_DATA_WIDTH(DW), .FIFO_DEPTH(DEPTH), .APB_ADDR_WIDTH(AW)) UUT (.*);

    initial pclk = 1'b0;
    always #4 pclk = ~pclk;

    ////////////////////////////////
    // Helpers
    ////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
    endtask

    // Chunk fits the word and word plus offset splits into whole chunks
    function automatic bit is_legal(input int off, input int size);
        return size != 0 && off + size <= BYTES && (BYTES + off) % size == 0;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
        @(negedge pclk);
        paddr = AW'(addr);
        pwdata = data;
        pwrite = 1'b1;
        psel = 1'b1;
        penable = 1'b0;
        @(negedge pclk);
        penable = 1'b1;
        err = pslverr;
        check_val("pready", 32'h1, 32'(pready));
        @(negedge pclk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        @(negedge pclk);
        paddr = AW'(addr);
        pwrite = 1'b0;
        psel = 1'b1;
        penable = 1'b0;
        @(negedge pclk);
        penable = 1'b1;
        data = prdata;
        check_val("pready", 32'h1, 32'(pready));
        // Reads never raise an error
        check_val("pslverr", 32'h0, 32'(pslverr));
        @(negedge pclk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic rx_start(input logic [31:0] data, input int off, input int size);
        md_rx_valid = 1'b1;
        md_rx_data = data;
        md_rx_offset = 2'(off);
        md_rx_size = 3'(size);
    endtask

    // Wait for the ready pulse, update the model on the handshake
    task automatic rx_wait(input int limit, output bit acc);
        bit legal;
        acc = 1'b0;
        for (int i = 0; i < limit && !acc; i++) begin
            @(negedge pclk);
            if (md_rx_ready) begin
                acc = 1'b1;
                legal = is_legal(md_rx_offset, md_rx_size);
                check_val("md_rx_err", 32'(!legal), 32'(md_rx_err));
                if (legal) begin
                    for (int b = 0; b < md_rx_size; b++) begin
                        model_q.push_back(md_rx_data[8*(md_rx_offset+b) +: 8]);
                    end
                end
                @(negedge pclk);
                md_rx_valid = 1'b0;
            end
        end
    endtask

    task automatic send(input bit legal);
        logic [31:0] data;
        logic [31:0] off;
        logic [31:0] size;
        bit          acc;
        do begin
            rand_bits(2, off);
            rand_bits(3, size);
        end while (is_legal(off, size) != legal);
        rand_bits(32, data);
        rx_start(data, off, size);
        rx_wait(100, acc);
        if (!acc) begin
            $display("receive transfer was never accepted");
            errors++;
        end
    endtask

    // Pad with single bytes to a whole chunk, then wait until all bytes left
    task automatic drain();
        logic [31:0] data;
        bit          acc;
        int          n;
        while (model_q.size() % exp_size != 0) begin
            rand_bits(32, data);
            rx_start(data, 0, 1);
            rx_wait(100, acc);
        end
        n = 0;
        while ((model_q.size() != 0 || md_tx_valid) && n < 2000) begin
            @(negedge pclk);
            n++;
        end
        if (n == 2000) begin
            $display("output did not drain, %0d bytes left in model", model_q.size());
            errors++;
        end
    endtask

    task automatic set_ctrl(input int size, input int off, input bit clr);
        reg_word_t w;
        logic      err;
        drain();
        w = '0;
        w.ctrl.size = 3'(size);
        w.ctrl.offset = 2'(off);
        w.ctrl.clr = clr;
        apb_write(ADDR_CTRL, w, err);
        check_val("pslverr", 32'h0, 32'(err));
        exp_size = size;
        exp_offset = off;
    endtask

    task automatic report(input int num, input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - err_before);
        end
    endtask

    ////////////////////////////////
    // Transmit monitor and sink
    ////////////////////////////////
    always @(negedge pclk) begin
        // Ready for the coming edge, the handshake checked below ends on that edge
        if (tx_rand) begin
            rdy_lfsr = lfsr_next(rdy_lfsr);
            md_tx_ready = rdy_lfsr[0];
        end else begin
            md_tx_ready = 1'b0;
        end
        if (rst_n && md_tx_valid && md_tx_ready) begin
            check_val("md_tx_size", 32'(exp_size), 32'(md_tx_size));
            check_val("md_tx_offset", 32'(exp_offset), 32'(md_tx_offset));
            for (int l = 0; l < BYTES; l++) begin
                if (l >= exp_offset && l < exp_offset + exp_size) begin
                    if (model_q.size() == 0) begin
                        $display("transmit byte arrived with nothing expected");
                        errors++;
                    end else begin
                        check_val("md_tx_data byte", 32'(model_q.pop_front()),
                                  32'(md_tx_data[8*l +: 8]));
                    end
                end else begin
                    check_val("md_tx_data idle lane", 32'h0, 32'(md_tx_data[8*l +: 8]));
                end
            end
        end
    end

    // Watchdog
    initial begin
        repeat (TOTAL_XFERS * CYCLES_PER_XFER) @(posedge pclk);
        $display("watchdog expired, the run took too long");
        $display("TESTS FAILED");
        $finish;
    end

    ////////////////////////////////
    // Test sequence
    ////////////////////////////////
    initial begin
        reg_word_t   w;
        logic [31:0] rd;
        logic        err;
        bit          acc;
        bit          blocked;
        logic [31:0] r;
        int          e0;
        int          illegal_sent;

        rst_n = 1'b0;
        paddr = '0;
        pwrite = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwdata = '0;
        md_rx_valid = 1'b0;
        md_rx_data = '0;
        md_rx_offset = '0;
        md_rx_size = '0;
        md_tx_ready = 1'b0;
        repeat (16) @(posedge pclk);
        @(negedge pclk);
        rst_n = 1'b1;

        // 1: reset values and CTRL write checks
        e0 = errors;
        apb_read(ADDR_CTRL, rd);
        check_val("CTRL", 32'(BYTES), rd);
        apb_read(ADDR_STATUS, rd);
        check_val("STATUS", 32'h0, rd);
        set_ctrl(2, 2, 1'b0);
        apb_read(ADDR_CTRL, rd);
        check_val("CTRL", 32'h202, rd);
        w = '0;
        apb_write(ADDR_CTRL, w, err);
        check_val("pslverr", 32'h1, 32'(err));
        apb_read(ADDR_CTRL, rd);
        check_val("CTRL", 32'h202, rd);
        report(1, "reset and registers", e0);

        // 2: drops saturate at 255, CLR clears
        e0 = errors;
        set_ctrl(BYTES, 0, 1'b0);
        for (int i = 0; i < 260; i++) send(1'b0);
        apb_read(ADDR_STATUS, rd);
        w = rd;
        check_val("STATUS.CNT_DROP", 32'd255, 32'(w.status.cnt_drop));
        set_ctrl(BYTES, 0, 1'b1);
        apb_read(ADDR_STATUS, rd);
        w = rd;
        check_val("STATUS.CNT_DROP", 32'h0, 32'(w.status.cnt_drop));
        report(2, "drops", e0);

        // 3: alignment under several CTRL settings
        e0 = errors;
        set_ctrl(4, 0, 1'b0);
        for (int i = 0; i < 40; i++) send(1'b1);
        set_ctrl(2, 0, 1'b0);
        for (int i = 0; i < 40; i++) send(1'b1);
        set_ctrl(2, 2, 1'b0);
        for (int i = 0; i < 40; i++) send(1'b1);
        set_ctrl(1, 3, 1'b0);
        for (int i = 0; i < 40; i++) send(1'b1);
        set_ctrl(1, 0, 1'b0);
        for (int i = 0; i < 40; i++) send(1'b1);
        drain();
        report(3, "alignment", e0);

        // 4: back-pressure fills the FIFO
        e0 = errors;
        set_ctrl(4, 0, 1'b0);
        tx_rand = 1'b0;
        blocked = 1'b0;
        for (int i = 0; i < 40 && !blocked; i++) begin
            rand_bits(32, r);
            rx_start(r, 0, 4);
            rx_wait(30, acc);
            blocked = !acc;
        end
        if (!blocked) begin
            $display("receive ready never stayed low with the FIFO full");
            errors++;
        end
        apb_read(ADDR_STATUS, rd);
        w = rd;
        check_val("STATUS.RX_LVL", 32'(DEPTH), 32'(w.status.rx_lvl));
        tx_rand = 1'b1;
        if (blocked) begin
            rx_wait(200, acc);
            if (!acc) begin
                $display("pending receive transfer not accepted after release");
                errors++;
            end
        end
        drain();
        report(4, "back-pressure", e0);

        // 5: legal and illegal transfers interleaved
        e0 = errors;
        set_ctrl(2, 0, 1'b1);
        illegal_sent = 0;
        for (int i = 0; i < 60; i++) begin
            rand_bits(1, r);
            if (r[0]) illegal_sent++;
            send(!r[0]);
        end
        drain();
        apb_read(ADDR_STATUS, rd);
        w = rd;
        check_val("STATUS.CNT_DROP", 32'(illegal_sent), 32'(w.status.cnt_drop));
        report(5, "mixed stream", e0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/aligner_pkg.sv
// Package with register addresses, field widths, register word union and legality check
package aligner_pkg;

    // APB data word and status counter widths
    localparam int unsigned APB_DATA_WIDTH = 32;
    localparam int unsigned CNT_DROP_WIDTH = 8;

    // Register field widths
    localparam int unsigned CTRL_SIZE_WIDTH     = 3;
    localparam int unsigned CTRL_OFFSET_WIDTH   = 2;
    localparam int unsigned STATUS_RX_LVL_WIDTH = 4;

    // Register map
    localparam logic [11:0] ADDR_CTRL   = 12'h000;
    localparam logic [11:0] ADDR_STATUS = 12'h00C;

    //////////////////////////////
    // Register word, seen as CTRL or as STATUS
    //////////////////////////////
    typedef union packed {
        struct packed {
            logic [APB_DATA_WIDTH-18:0]       rsvd_hi;
            logic                             clr;
            logic [7-CTRL_OFFSET_WIDTH:0]     rsvd_mid;
            logic [CTRL_OFFSET_WIDTH-1:0]     offset;
            logic [7-CTRL_SIZE_WIDTH:0]       rsvd_lo;
            logic [CTRL_SIZE_WIDTH-1:0]       size;
        } ctrl;
        struct packed {
            logic [APB_DATA_WIDTH-13:0]       rsvd;
            logic [STATUS_RX_LVL_WIDTH-1:0]   rx_lvl;
            logic [CNT_DROP_WIDTH-1:0]        cnt_drop;
        } status;
    } reg_word_t;

    // Legal (offset, size) pair for a word of byte_cnt bytes
    function automatic logic offset_size_legal(input int unsigned byte_cnt,
                                               input int unsigned offset,
                                               input int unsigned size);
        if (size == 0) return 1'b0;
        // Chunk must fit inside the word
        if (offset + size > byte_cnt) return 1'b0;
        return ((byte_cnt + offset) % size) == 0;
    endfunction

endpackage

//--- verilog/aligner_top.sv
// Aligner top level: receive controller, FIFO, aligning consumer and APB registers
module aligner_top import aligner_pkg::*; #(
    parameter int unsigned ALGN_DATA_WIDTH = 32,
    parameter int unsigned FIFO_DEPTH      = 8,
    parameter int unsigned APB_ADDR_WIDTH  = 16
) (
    input  logic                                 pclk,
    input  logic                                 rst_n,

    // APB slave
    input  logic [APB_ADDR_WIDTH-1:0]            paddr,
    input  logic                                 pwrite,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic [APB_DATA_WIDTH-1:0]            pwdata,
    output logic                                 pready,
    output logic [APB_DATA_WIDTH-1:0]            prdata,
    output logic                                 pslverr,

    // MD receive
    input  logic                                 md_rx_valid,
    input  logic [ALGN_DATA_WIDTH-1:0]           md_rx_data,
    input  logic [$clog2(ALGN_DATA_WIDTH/8)-1:0] md_rx_offset,
    input  logic [$clog2(ALGN_DATA_WIDTH/8):0]   md_rx_size,
    output logic                                 md_rx_ready,
    output logic                                 md_rx_err,

    // MD transmit
    output logic                                 md_tx_valid,
    output logic [ALGN_DATA_WIDTH-1:0]           md_tx_data,
    output logic [$clog2(ALGN_DATA_WIDTH/8)-1:0] md_tx_offset,
    output logic [$clog2(ALGN_DATA_WIDTH/8):0]   md_tx_size,
    input  logic                                 md_tx_ready
);

    localparam int unsigned OFFSET_WIDTH = $clog2(ALGN_DATA_WIDTH / 8);
    localparam int unsigned SIZE_WIDTH   = OFFSET_WIDTH + 1;
    localparam int unsigned ENTRY_WIDTH  = ALGN_DATA_WIDTH + OFFSET_WIDTH + SIZE_WIDTH;
    localparam int unsigned LEVEL_WIDTH  = $clog2(FIFO_DEPTH) + 1;

    logic                      push;
    logic [ENTRY_WIDTH-1:0]    push_data;
    logic                      pop;
    logic [ENTRY_WIDTH-1:0]    pop_data;
    logic                      full;
    logic                      empty;
    logic [LEVEL_WIDTH-1:0]    rx_lvl;
    logic [CNT_DROP_WIDTH-1:0] cnt_drop;
    logic [SIZE_WIDTH-1:0]     ctrl_size;
    logic [OFFSET_WIDTH-1:0]   ctrl_offset;
    logic                      ctrl_clr;

    // No wait states
    assign pready = 1'b1;

    md_rx_ctrl #(.ALGN_DATA_WIDTH(ALGN_DATA_WIDTH)) rx_ctrl (
        .pclk(pclk), .rst_n(rst_n),
        .md_rx_valid(md_rx_valid), .md_rx_data(md_rx_data),
        .md_rx_offset(md_rx_offset), .md_rx_size(md_rx_size),
        .md_rx_ready(md_rx_ready), .md_rx_err(md_rx_err),
        .full(full), .push(push), .push_data(push_data),
        .ctrl_clr(ctrl_clr), .cnt_drop(cnt_drop)
    );

    sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .DATA_WIDTH(ENTRY_WIDTH)) rx_fifo (
        .pclk(pclk), .rst_n(rst_n),
        .push(push), .push_data(push_data),
        .pop(pop), .pop_data(pop_data),
        .full(full), .empty(empty), .level(rx_lvl)
    );

    md_tx_aligner #(.ALGN_DATA_WIDTH(ALGN_DATA_WIDTH)) tx_aligner (
        .pclk(pclk), .rst_n(rst_n),
        .pop_data(pop_data), .empty(empty), .pop(pop),
        .ctrl_size(ctrl_size), .ctrl_offset(ctrl_offset),
        .md_tx_valid(md_tx_valid), .md_tx_data(md_tx_data),
        .md_tx_offset(md_tx_offset), .md_tx_size(md_tx_size),
        .md_tx_ready(md_tx_ready)
    );

    apb_regs #(
        .APB_ADDR_WIDTH(APB_ADDR_WIDTH),
        .ALGN_DATA_WIDTH(ALGN_DATA_WIDTH),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) regs (
        .pclk(pclk), .rst_n(rst_n),
        .paddr(paddr), .pwrite(pwrite), .psel(psel), .penable(penable),
        .pwdata(pwdata), .prdata(prdata), .pslverr(pslverr),
        .cnt_drop(cnt_drop), .rx_lvl(rx_lvl),
        .ctrl_size(ctrl_size), .ctrl_offset(ctrl_offset), .ctrl_clr(ctrl_clr)
    );

endmodule

//--- verilog/apb_regs.sv
// APB slave with the CTRL register and the STATUS read path
module apb_regs import aligner_pkg::*; #(
    parameter int unsigned APB_ADDR_WIDTH  = 16,
    parameter int unsigned ALGN_DATA_WIDTH = 32,
    parameter int unsigned FIFO_DEPTH      = 8
) (
    input  logic                                 pclk,
    input  logic                                 rst_n,

    input  logic [APB_ADDR_WIDTH-1:0]            paddr,
    input  logic                                 pwrite,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic [APB_DATA_WIDTH-1:0]            pwdata,
    output logic [APB_DATA_WIDTH-1:0]            prdata,
    output logic                                 pslverr,

    input  logic [CNT_DROP_WIDTH-1:0]            cnt_drop,
    input  logic [$clog2(FIFO_DEPTH):0]          rx_lvl,

    output logic [$clog2(ALGN_DATA_WIDTH/8):0]   ctrl_size,
    output logic [$clog2(ALGN_DATA_WIDTH/8)-1:0] ctrl_offset,
    output logic                                 ctrl_clr
);

    localparam int unsigned BYTES        = ALGN_DATA_WIDTH / 8;
    localparam int unsigned OFFSET_WIDTH = $clog2(BYTES);
    localparam int unsigned SIZE_WIDTH   = $clog2(BYTES) + 1;

    reg_word_t wr_word;
    reg_word_t rd_word;
    logic      is_ctrl;
    logic      is_status;
    logic      setup;
    logic      ctrl_wr;
    logic      wr_legal;

    assign wr_word   = pwdata;
    assign is_ctrl   = (paddr == APB_ADDR_WIDTH'(ADDR_CTRL));
    assign is_status = (paddr == APB_ADDR_WIDTH'(ADDR_STATUS));
    assign setup     = psel && !penable;
    // CTRL write in the access phase
    assign ctrl_wr   = psel && penable && pwrite && is_ctrl;
    assign wr_legal  = offset_size_legal(BYTES, wr_word.ctrl.offset, wr_word.ctrl.size);

    //////////////////////////////
    // Read word
    //////////////////////////////
    always_comb begin
        rd_word = '0;
        if (is_ctrl) begin
            // CLR always reads back as 0
            rd_word.ctrl.size   = CTRL_SIZE_WIDTH'(ctrl_size);
            rd_word.ctrl.offset = CTRL_OFFSET_WIDTH'(ctrl_offset);
        end else if (is_status) begin
            rd_word.status.cnt_drop = cnt_drop;
            rd_word.status.rx_lvl   = STATUS_RX_LVL_WIDTH'(rx_lvl);
        end
    end

    // Read data and error sampled in setup, shown in access
    always_ff @(posedge pclk) begin
        if (setup && !pwrite) begin
            prdata <= rd_word;
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            pslverr <= 1'b0;
        end else if (setup) begin
            pslverr <= pwrite && is_ctrl && !wr_legal;
        end else begin
            pslverr <= 1'b0;
        end
    end

    //////////////////////////////
    // CTRL register
    //////////////////////////////
    // Rejected writes change nothing
    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            ctrl_size   <= SIZE_WIDTH'(BYTES);
            ctrl_offset <= '0;
            ctrl_clr    <= 1'b0;
        end else begin
            ctrl_clr <= ctrl_wr && wr_legal && wr_word.ctrl.clr;
            if (ctrl_wr && wr_legal) begin
                ctrl_size   <= SIZE_WIDTH'(wr_word.ctrl.size);
                ctrl_offset <= OFFSET_WIDTH'(wr_word.ctrl.offset);
            end
        end
    end

endmodule

//--- verilog/md_rx_ctrl.sv
// MD receive controller: legality check, ready pulse, FIFO push and drop counter
module md_rx_ctrl import aligner_pkg::*; #(
    parameter int unsigned ALGN_DATA_WIDTH = 32
) (
    input  logic                                 pclk,
    input  logic                                 rst_n,

    input  logic                                 md_rx_valid,
    input  logic [ALGN_DATA_WIDTH-1:0]           md_rx_data,
    input  logic [$clog2(ALGN_DATA_WIDTH/8)-1:0] md_rx_offset,
    input  logic [$clog2(ALGN_DATA_WIDTH/8):0]   md_rx_size,
    output logic                                 md_rx_ready,
    output logic                                 md_rx_err,

    input  logic                                 full,
    output logic                                 push,
    output logic [ALGN_DATA_WIDTH+2*$clog2(ALGN_DATA_WIDTH/8):0] push_data,

    input  logic                                 ctrl_clr,
    output logic [CNT_DROP_WIDTH-1:0]            cnt_drop
);

    localparam int unsigned BYTES = ALGN_DATA_WIDTH / 8;

    logic legal;
    logic rx_done;

    // Check the pair currently on the bus
    assign legal   = offset_size_legal(BYTES, md_rx_offset, md_rx_size);
    assign rx_done = md_rx_valid && md_rx_ready;

    //////////////////////////////
    // Ready and error pulses
    //////////////////////////////
    // Ready rises one cycle after valid is seen
    // Legal transfers wait for FIFO space, illegal ones go through at once
    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            md_rx_ready <= 1'b0;
            md_rx_err   <= 1'b0;
        end else begin
            md_rx_ready <= md_rx_valid && !md_rx_ready && (!legal || !full);
            // Err only ever rises with ready
            md_rx_err   <= md_rx_valid && !md_rx_ready && !legal;
        end
    end

    //////////////////////////////
    // FIFO push
    //////////////////////////////
    // Fields are still held by the source in the handshake cycle
    assign push      = rx_done && !md_rx_err;
    assign push_data = {md_rx_data, md_rx_offset, md_rx_size};

    // Saturating drop counter
    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            cnt_drop <= '0;
        end else if (ctrl_clr) begin
            // Clear has priority over a drop in the same cycle
            cnt_drop <= '0;
        end else if (rx_done && md_rx_err && (cnt_drop != '1)) begin
            cnt_drop <= cnt_drop + 1'b1;
        end
    end

endmodule

//--- verilog/md_tx_aligner.sv
// Aligning consumer: byte buffer fed by FIFO entries, CTRL-sized MD transmit transfers
module md_tx_aligner #(
    parameter int unsigned ALGN_DATA_WIDTH = 32
) (
    input  logic                                 pclk,
    input  logic                                 rst_n,

    input  logic [ALGN_DATA_WIDTH+2*$clog2(ALGN_DATA_WIDTH/8):0] pop_data,
    input  logic                                 empty,
    output logic                                 pop,

    input  logic [$clog2(ALGN_DATA_WIDTH/8):0]   ctrl_size,
    input  logic [$clog2(ALGN_DATA_WIDTH/8)-1:0] ctrl_offset,

    output logic                                 md_tx_valid,
    output logic [ALGN_DATA_WIDTH-1:0]           md_tx_data,
    output logic [$clog2(ALGN_DATA_WIDTH/8)-1:0] md_tx_offset,
    output logic [$clog2(ALGN_DATA_WIDTH/8):0]   md_tx_size,
    input  logic                                 md_tx_ready
);

    localparam int unsigned BYTES        = ALGN_DATA_WIDTH / 8;
    localparam int unsigned OFFSET_WIDTH = $clog2(BYTES);
    localparam int unsigned SIZE_WIDTH   = $clog2(BYTES) + 1;
    localparam int unsigned BUF_BYTES    = 2 * BYTES;
    localparam int unsigned CNT_WIDTH    = $clog2(BUF_BYTES) + 1;

    logic [ALGN_DATA_WIDTH-1:0] entry_data;
    logic [OFFSET_WIDTH-1:0]    entry_offset;
    logic [SIZE_WIDTH-1:0]      entry_size;
    logic [7:0]                 entry_bytes [BYTES];

    logic [7:0]                 byte_buf [BUF_BYTES];
    logic [7:0]                 next_buf [BUF_BYTES];
    logic [CNT_WIDTH-1:0]       byte_cnt;
    logic [CNT_WIDTH-1:0]       next_cnt;
    logic                       tx_done;
    logic                       load;
    logic [ALGN_DATA_WIDTH-1:0] tx_word;

    // Entry layout is {data, offset, size}
    assign entry_data   = pop_data[SIZE_WIDTH+OFFSET_WIDTH +: ALGN_DATA_WIDTH];
    assign entry_offset = pop_data[SIZE_WIDTH +: OFFSET_WIDTH];
    assign entry_size   = pop_data[SIZE_WIDTH-1:0];

    always_comb begin
        for (int b = 0; b < BYTES; b++) begin
            entry_bytes[b] = entry_data[8*b +: 8];
        end
    end

    assign tx_done = md_tx_valid && md_tx_ready;
    // New chunk once the previous one is gone, back to back when it ends now
    assign load    = (!md_tx_valid || tx_done) && (byte_cnt >= CNT_WIDTH'(ctrl_size));
    // Room for a whole data word
    assign pop     = !empty && (byte_cnt <= CNT_WIDTH'(BYTES));

    //////////////////////////////
    // Buffer next state
    //////////////////////////////
    always_comb begin
        int base;
        next_buf = byte_buf;
        next_cnt = byte_cnt;
        // Shift out the oldest ctrl_size bytes
        if (load) begin
            for (int i = 0; i < BUF_BYTES; i++) begin
                if (i + int'(ctrl_size) < BUF_BYTES) begin
                    next_buf[i] = byte_buf[i + int'(ctrl_size)];
                end else begin
                    next_buf[i] = 8'h00;
                end
            end
            next_cnt = byte_cnt - CNT_WIDTH'(ctrl_size);
        end
        base = int'(next_cnt);
        // Append valid bytes of the head entry, lowest lane first
        if (pop) begin
            for (int i = 0; i < BUF_BYTES; i++) begin
                if (i >= base && i < base + int'(entry_size)) begin
                    next_buf[i] = entry_bytes[i - base + int'(entry_offset)];
                end
            end
            next_cnt = next_cnt + CNT_WIDTH'(entry_size);
        end
    end

    // Oldest bytes placed at lane ctrl_offset upward, other lanes zero
    always_comb begin
        tx_word = '0;
        for (int l = 0; l < BYTES; l++) begin
            if (l >= int'(ctrl_offset) && l < int'(ctrl_offset) + int'(ctrl_size)) begin
                tx_word[8*l +: 8] = byte_buf[l - int'(ctrl_offset)];
            end
        end
    end

    //////////////////////////////
    // Registers
    //////////////////////////////
    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            byte_cnt    <= '0;
            md_tx_valid <= 1'b0;
        end else begin
            byte_cnt <= next_cnt;
            if (load) begin
                md_tx_valid <= 1'b1;
            end else if (tx_done) begin
                md_tx_valid <= 1'b0;
            end
        end
    end

    // Byte storage and transmit fields
    always_ff @(posedge pclk) begin
        byte_buf <= next_buf;
        if (load) begin
            md_tx_data   <= tx_word;
            md_tx_offset <= ctrl_offset;
            md_tx_size   <= ctrl_size;
        end
    end

endmodule

//--- verilog/sync_fifo.sv
// Synchronous show-ahead FIFO with full, empty and level outputs
module sync_fifo #(
    parameter int unsigned FIFO_DEPTH = 8,
    parameter int unsigned DATA_WIDTH = 8
) (
    input  logic                          pclk,
    input  logic                          rst_n,

    input  logic                          push,
    input  logic [DATA_WIDTH-1:0]         push_data,

    input  logic                          pop,
    output logic [DATA_WIDTH-1:0]         pop_data,

    output logic                          full,
    output logic                          empty,
    output logic [$clog2(FIFO_DEPTH):0]   level
);

    localparam int unsigned PTR_WIDTH = $clog2(FIFO_DEPTH);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]  wr_ptr;
    logic [PTR_WIDTH-1:0]  rd_ptr;
    logic                  do_push;
    logic                  do_pop;

    // Pop on empty is ignored
    assign do_pop  = pop && !empty;
    // A push into a full FIFO is taken only when a pop frees the head slot
    assign do_push = push && (!full || do_pop);

    assign full     = (level == FIFO_DEPTH);
    assign empty    = (level == '0);
    // Show-ahead head entry
    assign pop_data = mem[rd_ptr];

    //////////////////////////////
    // Pointers and level
    //////////////////////////////
    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Level holds when both happen in one cycle
            if (do_push && !do_pop) begin
                level <= level + 1'b1;
            end else if (do_pop && !do_push) begin
                level <= level - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge pclk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule
